//--- Makefile
# Verilator flow for the memory command engine

VERILATOR ?= verilator
TOP       ?= tb_mem_cmd_top
FILELIST  ?= mem_cmd_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the simulator status does not
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cmd_buffer/cmd_buffer.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module cmd_buffer
(
  input  logic           clka,
  input  logic           rst,

  // commands from the producer
  cmd_credit_if.receiver rx,
  // commands towards the consumer
  cmd_credit_if.sender   tx
);

  localparam int CNT_W = $clog2(`CMD_BUF_DEPTH + 1);
  localparam int CCR_W = $clog2(`CONS_Q_DEPTH + 1);

  // field positions inside a packed entry
  localparam int DATA_LSB = `MEM_BE_W;
  localparam int ADDR_LSB = DATA_LSB + `MEM_DATA_W;
  localparam int OP_BIT   = ADDR_LSB + `MEM_ADDR_W;

  logic [`CMD_BUF_PTR_W-1:0] wr_ptr;
  logic [`CMD_BUF_PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0]          count;
  logic [CCR_W-1:0]          cons_cred;
  logic                      rd_en;
  logic                      send_q;
  logic [`CMD_WORD_W-1:0]    wr_word;
  logic [`CMD_WORD_W-1:0]    rd_word;

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  assign wr_word = {rx.op, rx.addr, rx.wdata, rx.be};

  // head is read when present and the consumer has room
  assign rd_en = (count != '0) && (cons_cred != '0);

  cmd_sdp_ram u_ram
  (
    .clka  (clka),
    .we    (rx.valid),
    .waddr (wr_ptr),
    .wdata (wr_word),
    .re    (rd_en),
    .raddr (rd_ptr),
    .rdata (rd_word)
  );

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------

  // pointers wrap at the buffer depth
  always_ff @(posedge clka)
  begin
    if (rst)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      cons_cred <= CCR_W'(`CONS_Q_DEPTH);
      send_q    <= 1'b0;
    end
    else
    begin
      if (rx.valid)
        wr_ptr <= wr_ptr + `CMD_BUF_PTR_W'(1);
      if (rd_en)
        rd_ptr <= rd_ptr + `CMD_BUF_PTR_W'(1);
      case ({rx.valid, rd_en})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
      // consumer slots, taken at read and given back by its credit
      case ({rd_en, tx.credit})
        2'b10:   cons_cred <= cons_cred - CCR_W'(1);
        2'b01:   cons_cred <= cons_cred + CCR_W'(1);
        default: cons_cred <= cons_cred;
      endcase
      // ram output is valid one cycle after the read
      send_q <= rd_en;
    end
  end

  // unpack the entry onto the consumer link
  assign tx.valid = send_q;
  assign tx.op    = mem_pkg::mem_op_e'(rd_word[OP_BIT]);
  assign tx.addr  = rd_word[ADDR_LSB +: `MEM_ADDR_W];
  assign tx.wdata = rd_word[DATA_LSB +: `MEM_DATA_W];
  assign tx.be    = rd_word[0 +: `MEM_BE_W];

  // slot handed back to the producer as the entry goes out
  assign rx.credit = send_q;

endmodule

//--- cmd_buffer/cmd_sdp_ram.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module cmd_sdp_ram
(
  input  logic                      clka,

  // write port
  input  logic                      we,
  input  logic [`CMD_BUF_PTR_W-1:0] waddr,
  input  logic [`CMD_WORD_W-1:0]    wdata,

  // read port
  input  logic                      re,
  input  logic [`CMD_BUF_PTR_W-1:0] raddr,
  output logic [`CMD_WORD_W-1:0]    rdata
);

  // one packed command per entry
  logic [`CMD_WORD_W-1:0] mem [`CMD_BUF_DEPTH];

  // write port
  always_ff @(posedge clka)
  begin
    if (we)
      mem[waddr] <= wdata;
  end

  // read port, output holds while re is low
  always_ff @(posedge clka)
  begin
    if (re)
      rdata <= mem[raddr];
  end

endmodule

//--- common/cmd_credit_if.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

// credit based command link
// one valid pulse per command, one credit pulse per freed slot
interface cmd_credit_if;

  // command strobe, sender side
  logic               valid;
  // command fields
  mem_pkg::mem_op_e   op;
  mem_pkg::mem_addr_t addr;
  mem_pkg::mem_data_t wdata;
  mem_pkg::mem_be_t   be;
  // slot freed, receiver side
  logic               credit;

  modport sender
  (
    output valid,
    output op,
    output addr,
    output wdata,
    output be,
    input  credit
  );

  modport receiver
  (
    input  valid,
    input  op,
    input  addr,
    input  wdata,
    input  be,
    output credit
  );

endinterface

//--- common/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// --------------------------------------------------
// data RAM geometry
// --------------------------------------------------

// word address, 256 words
`define MEM_ADDR_W 8
// one RAM word
`define MEM_DATA_W 64
// one enable per byte lane
`define MEM_BE_W (`MEM_DATA_W / 8)

// --------------------------------------------------
// command path sizes
// --------------------------------------------------

// buffer entries and pointer width
`define CMD_BUF_DEPTH 8
`define CMD_BUF_PTR_W 3
// consumer queue slots
`define CONS_Q_DEPTH 2
// packed command, op + addr + wdata + be
`define CMD_WORD_W (1 + `MEM_ADDR_W + `MEM_DATA_W + `MEM_BE_W)

`endif

//--- common/mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

  // --------------------------------------------------
  // command opcodes
  // --------------------------------------------------
  typedef enum logic
  {
    MEM_WRITE = 1'b0,
    MEM_READ  = 1'b1
  } mem_op_e;

  // consumer sequencer
  // issue pops the queue, hold waits for the response handshake
  typedef enum logic
  {
    CONS_ISSUE    = 1'b0,
    CONS_RSP_HOLD = 1'b1
  } cons_state_e;

  // --------------------------------------------------
  // payload vectors
  // --------------------------------------------------
  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [`MEM_DATA_W-1:0] mem_data_t;
  // bit n enables byte lane n
  typedef logic [`MEM_BE_W-1:0]   mem_be_t;

endpackage

//--- dv/tb_mem_cmd_top.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_mem_cmd_top;

  localparam int CLK_HALF    = 10;
  localparam int RAND_CMDS   = 400;
  // directed part, rounded up
  localparam int DIR_CMDS    = 40;
  localparam int WDOG_CYCLES = (RAND_CMDS + DIR_CMDS) * 40;
  // most commands taken before a held response stops input
  localparam int STALL_MAX   = `CMD_BUF_DEPTH + `CONS_Q_DEPTH + 2;

  logic               clka;
  logic               rst;
  logic               cmd_valid;
  logic               cmd_ready;
  mem_pkg::mem_op_e   cmd_op;
  mem_pkg::mem_addr_t cmd_addr;
  mem_pkg::mem_data_t cmd_wdata;
  mem_pkg::mem_be_t   cmd_be;
  logic               rsp_valid;
  logic               rsp_ready;
  mem_pkg::mem_data_t rsp_data;

  // reference memory and expected read words
  mem_pkg::mem_data_t ref_mem [1 << `MEM_ADDR_W];
  mem_pkg::mem_data_t exp_q [$];

  int errors;
  int reads_checked;
  // rsp_ready mode, 0 high, 1 low, 2 random
  int rsp_mode;

  mem_cmd_top uut
  (
    .clka      (clka),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata),
    .cmd_be    (cmd_be),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
  );

  initial
  begin
    clka = 1'b0;
    forever #CLK_HALF clka = ~clka;
  end

  // --------------------------------------------------
  // reference model and helpers
  // --------------------------------------------------

  // write merges the enabled lanes, read returns the stored word
  function automatic mem_pkg::mem_data_t ref_apply(input mem_pkg::mem_op_e op,
      input mem_pkg::mem_addr_t addr, input mem_pkg::mem_data_t wdata,
      input mem_pkg::mem_be_t be);
    mem_pkg::mem_data_t word;
    word = ref_mem[addr];
    if (op == mem_pkg::MEM_WRITE)
    begin
      for (int b = 0; b < `MEM_BE_W; b++)
      begin
        if (be[b])
          word[b*8 +: 8] = wdata[b*8 +: 8];
      end
      ref_mem[addr] = word;
    end
    return word;
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
      input string what);
    if (actual !== expected)
    begin
      errors++;
      $display("** Error at time %0t: %s, got %h, expected %h", $time, what, actual,
               expected);
    end
  endtask

  // accepted command into the model, reads queue their word
  task automatic note_accept();
    mem_pkg::mem_data_t word;
    word = ref_apply(cmd_op, cmd_addr, cmd_wdata, cmd_be);
    if (cmd_op == mem_pkg::MEM_READ)
      exp_q.push_back(word);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clka);
      #2;
    end
  endtask

  // entered 2 ns after a rising edge, leaves at the same point
  task automatic send_cmd(input mem_pkg::mem_op_e op, input mem_pkg::mem_addr_t addr,
      input mem_pkg::mem_data_t wdata, input mem_pkg::mem_be_t be);
    logic taken;
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_addr  = addr;
    cmd_wdata = wdata;
    cmd_be    = be;
    taken     = 1'b0;
    while (!taken)
    begin
      // cmd_ready settled mid cycle, transfer on the next edge
      @(negedge clka);
      taken = cmd_ready;
      if (taken)
        note_accept();
      @(posedge clka);
      #2;
    end
    cmd_valid = 1'b0;
  endtask

  // ready forced high, wait out all outstanding reads
  task automatic drain_responses();
    rsp_mode = 0;
    while (exp_q.size() != 0)
      idle_cycles(1);
    idle_cycles(4);
  endtask

  // --------------------------------------------------
  // response side
  // --------------------------------------------------

  // mode picked up at the edge, value driven after the usual delay
  initial
  begin : rsp_drive
    logic next_ready;
    forever
    begin
      @(posedge clka);
      case (rsp_mode)
        1:       next_ready = 1'b0;
        2:       next_ready = ($urandom_range(0, 2) != 0);
        default: next_ready = 1'b1;
      endcase
      #2;
      rsp_ready = next_ready;
    end
  end

  // handshake judged mid cycle, applies to the next edge
  initial
  begin : compare
    mem_pkg::mem_data_t held;
    mem_pkg::mem_data_t expected;
    logic               held_vld;
    held_vld = 1'b0;
    held     = '0;
    forever
    begin
      @(negedge clka);
      if (rst)
        held_vld = 1'b0;
      else
      begin
        if (held_vld && !rsp_valid)
        begin
          errors++;
          $display("response at time %0t was withdrawn before rsp_ready", $time);
        end
        if (held_vld && rsp_valid)
          check_value(rsp_data, held, "rsp_data changed while held");
        if (rsp_valid && rsp_ready)
        begin
          if (exp_q.size() == 0)
          begin
            errors++;
            $display("response at time %0t arrived with no read outstanding", $time);
          end
          else
          begin
            expected = exp_q.pop_front();
            check_value(rsp_data, expected, "read data");
            reads_checked++;
          end
          held_vld = 1'b0;
        end
        else if (rsp_valid)
        begin
          held     = rsp_data;
          held_vld = 1'b1;
        end
        else
          held_vld = 1'b0;
      end
    end
  end

  initial
  begin : watchdog
    repeat (WDOG_CYCLES) @(posedge clka);
    $display("run did not finish within %0d cycles, %0d reads still outstanding",
             WDOG_CYCLES, exp_q.size());
    $display("errors: %0d, reads checked: %0d", errors, reads_checked);
    $display("Regression failed");
    $finish;
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin : main
    mem_pkg::mem_data_t word;
    int                 accepted;
    int                 idle;
    void'($urandom(32'hb9ba_70f0));
    errors        = 0;
    reads_checked = 0;
    rsp_mode      = 0;
    rst           = 1'b1;
    cmd_valid     = 1'b0;
    cmd_op        = mem_pkg::MEM_WRITE;
    cmd_addr      = '0;
    cmd_wdata     = '0;
    cmd_be        = '0;
    rsp_ready     = 1'b0;
    for (int i = 0; i < (1 << `MEM_ADDR_W); i++)
      ref_mem[i] = '0;
    repeat (10) @(posedge clka);
    #2;
    rst = 1'b0;

    // idle state after reset, cleared array
    check_value(64'(cmd_ready), 64'd1, "cmd_ready after reset");
    check_value(64'(rsp_valid), 64'd0, "rsp_valid after reset");
    send_cmd(mem_pkg::MEM_READ, 8'h00, '0, '0);
    send_cmd(mem_pkg::MEM_READ, 8'hff, '0, '0);
    send_cmd(mem_pkg::MEM_READ, mem_pkg::mem_addr_t'($urandom), '0, '0);
    drain_responses();

    // full mask write then read back
    word = {$urandom, $urandom};
    send_cmd(mem_pkg::MEM_WRITE, 8'h21, word, '1);
    send_cmd(mem_pkg::MEM_READ, 8'h21, '0, '0);
    send_cmd(mem_pkg::MEM_WRITE, 8'h22, ~word, '1);
    send_cmd(mem_pkg::MEM_READ, 8'h22, '0, '0);
    drain_responses();

    // partial lanes on one word
    send_cmd(mem_pkg::MEM_WRITE, 8'h40, 64'h0011_2233_4455_6677, '1);
    send_cmd(mem_pkg::MEM_WRITE, 8'h40, 64'hffee_ddcc_bbaa_9988, 8'h0f);
    send_cmd(mem_pkg::MEM_READ, 8'h40, '0, '0);
    send_cmd(mem_pkg::MEM_WRITE, 8'h40, {$urandom, $urandom}, 8'ha5);
    send_cmd(mem_pkg::MEM_READ, 8'h40, '0, '0);
    // no lanes selected, word unchanged
    send_cmd(mem_pkg::MEM_WRITE, 8'h40, {$urandom, $urandom}, 8'h00);
    send_cmd(mem_pkg::MEM_READ, 8'h40, '0, '0);
    drain_responses();

    // back-pressure, reads pile up behind a held response
    rsp_mode  = 1;
    accepted  = 0;
    idle      = 0;
    cmd_valid = 1'b1;
    cmd_op    = mem_pkg::MEM_READ;
    cmd_addr  = mem_pkg::mem_addr_t'($urandom);
    cmd_wdata = '0;
    cmd_be    = '0;
    while (idle < 20 && accepted <= STALL_MAX)
    begin
      @(negedge clka);
      if (cmd_ready)
      begin
        note_accept();
        accepted++;
        idle = 0;
      end
      else
        idle++;
      @(posedge clka);
      #2;
      if (idle == 0)
        cmd_addr = mem_pkg::mem_addr_t'($urandom);
    end
    cmd_valid = 1'b0;
    check_value(64'(accepted <= STALL_MAX), 64'd1, "commands taken before cmd_ready fell");
    check_value(64'(rsp_valid), 64'd1, "rsp_valid while stalled");
    idle_cycles(10);
    drain_responses();

    // random mix, random rsp_ready
    rsp_mode = 2;
    for (int n = 0; n < RAND_CMDS; n++)
    begin
      // narrow window so reads hit written words
      send_cmd(($urandom_range(0, 1) != 0) ? mem_pkg::MEM_READ : mem_pkg::MEM_WRITE,
               mem_pkg::mem_addr_t'($urandom_range(0, 31)), {$urandom, $urandom},
               mem_pkg::mem_be_t'($urandom));
      if ($urandom_range(0, 3) == 0)
        idle_cycles(1);
    end
    drain_responses();

    $display("errors: %0d, reads checked: %0d", errors, reads_checked);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- logic/cmd_producer.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module cmd_producer
(
  input  logic               clka,
  input  logic               rst,

  // top level command port
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  mem_pkg::mem_op_e   cmd_op,
  input  mem_pkg::mem_addr_t cmd_addr,
  input  mem_pkg::mem_data_t cmd_wdata,
  input  mem_pkg::mem_be_t   cmd_be,

  // link towards the command buffer
  cmd_credit_if.sender       tx
);

  // counter must reach the full buffer depth
  localparam int CRED_W = $clog2(`CMD_BUF_DEPTH + 1);

  logic [CRED_W-1:0] credit_cnt;
  logic              send;

  // --------------------------------------------------
  // acceptance
  // --------------------------------------------------

  // ready only while a buffer slot is known free
  assign cmd_ready = (credit_cnt != '0);
  assign send      = cmd_valid & cmd_ready;

  // accepted command leaves in the same cycle
  assign tx.valid = send;
  assign tx.op    = cmd_op;
  assign tx.addr  = cmd_addr;
  assign tx.wdata = cmd_wdata;
  assign tx.be    = cmd_be;

  // --------------------------------------------------
  // credit counter
  // --------------------------------------------------

  // send takes one, returned credit gives one back
  // both in one cycle leaves the count unchanged
  always_ff @(posedge clka)
  begin
    if (rst)
    begin
      credit_cnt <= CRED_W'(`CMD_BUF_DEPTH);
    end
    else if (send && !tx.credit)
    begin
      credit_cnt <= credit_cnt - CRED_W'(1);
    end
    else if (!send && tx.credit)
    begin
      credit_cnt <= credit_cnt + CRED_W'(1);
    end
  end

endmodule

//--- logic/mem_cmd_top.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_cmd_top
(
  input  logic               clka,
  input  logic               rst,

  // command port, valid/ready
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  mem_pkg::mem_op_e   cmd_op,
  input  mem_pkg::mem_addr_t cmd_addr,
  input  mem_pkg::mem_data_t cmd_wdata,
  input  mem_pkg::mem_be_t   cmd_be,

  // response port, valid/ready
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output mem_pkg::mem_data_t rsp_data
);

  // --------------------------------------------------
  // internal credit links
  // --------------------------------------------------
  cmd_credit_if prod_to_buf ();
  cmd_credit_if buf_to_cons ();

  // top level handshake into credits
  cmd_producer u_producer
  (
    .clka      (clka),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata),
    .cmd_be    (cmd_be),
    .tx        (prod_to_buf.sender)
  );

  // deep command store
  cmd_buffer u_buffer
  (
    .clka (clka),
    .rst  (rst),
    .rx   (prod_to_buf.receiver),
    .tx   (buf_to_cons.sender)
  );

  // data ram and response path
  mem_consumer u_consumer
  (
    .clka      (clka),
    .rst       (rst),
    .rx        (buf_to_cons.receiver),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
  );

endmodule

//--- logic/mem_consumer.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_consumer
(
  input  logic               clka,
  input  logic               rst,

  // commands from the buffer
  cmd_credit_if.receiver     rx,

  // read responses
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output mem_pkg::mem_data_t rsp_data
);

  localparam int IDX_W = $clog2(`CONS_Q_DEPTH);
  localparam int CNT_W = $clog2(`CONS_Q_DEPTH + 1);

  // queue payload
  mem_pkg::mem_op_e    q_op    [`CONS_Q_DEPTH];
  mem_pkg::mem_addr_t  q_addr  [`CONS_Q_DEPTH];
  mem_pkg::mem_data_t  q_wdata [`CONS_Q_DEPTH];
  mem_pkg::mem_be_t    q_be    [`CONS_Q_DEPTH];

  logic [IDX_W-1:0]     wr_idx;
  logic [IDX_W-1:0]     rd_idx;
  logic [CNT_W-1:0]     q_cnt;
  mem_pkg::cons_state_e state;
  logic                 issue;
  logic                 head_rd;
  logic                 rd_pend;
  mem_pkg::mem_be_t     ram_we;
  mem_pkg::mem_data_t   ram_rdata;

  // --------------------------------------------------
  // command queue
  // --------------------------------------------------

  // slot write, the credit link keeps a slot free for every arrival
  always_ff @(posedge clka)
  begin
    if (rx.valid)
    begin
      q_op[wr_idx]    <= rx.op;
      q_addr[wr_idx]  <= rx.addr;
      q_wdata[wr_idx] <= rx.wdata;
      q_be[wr_idx]    <= rx.be;
    end
  end

  // pop one head per cycle, only while nothing is held
  assign issue   = (state == mem_pkg::CONS_ISSUE) && (q_cnt != '0);
  assign head_rd = (q_op[rd_idx] == mem_pkg::MEM_READ);

  // every pop frees a slot
  assign rx.credit = issue;

  always_ff @(posedge clka)
  begin
    if (rst)
    begin
      wr_idx <= '0;
      rd_idx <= '0;
      q_cnt  <= '0;
    end
    else
    begin
      if (rx.valid)
        wr_idx <= (wr_idx == IDX_W'(`CONS_Q_DEPTH - 1)) ? '0 : wr_idx + IDX_W'(1);
      if (issue)
        rd_idx <= (rd_idx == IDX_W'(`CONS_Q_DEPTH - 1)) ? '0 : rd_idx + IDX_W'(1);
      case ({rx.valid, issue})
        2'b10:   q_cnt <= q_cnt + CNT_W'(1);
        2'b01:   q_cnt <= q_cnt - CNT_W'(1);
        default: q_cnt <= q_cnt;
      endcase
    end
  end

  // --------------------------------------------------
  // ram sequencer
  // --------------------------------------------------

  // reads drive no lanes
  assign ram_we = head_rd ? '0 : q_be[rd_idx];

  sp_ram_bytewise u_ram
  (
    .clka  (clka),
    .en    (issue),
    .we    (ram_we),
    .addr  (q_addr[rd_idx]),
    .wdata (q_wdata[rd_idx]),
    .rdata (ram_rdata)
  );

  // a read stops issue right away, its data lands one cycle later
  always_ff @(posedge clka)
  begin
    if (rst)
    begin
      state     <= mem_pkg::CONS_ISSUE;
      rd_pend   <= 1'b0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      rd_pend <= issue && head_rd;
      case (state)
        mem_pkg::CONS_ISSUE:
        begin
          if (issue && head_rd)
            state <= mem_pkg::CONS_RSP_HOLD;
        end
        mem_pkg::CONS_RSP_HOLD:
        begin
          // back to issue once the response is taken
          if (rsp_valid && rsp_ready)
            state <= mem_pkg::CONS_ISSUE;
        end
        default: state <= mem_pkg::CONS_ISSUE;
      endcase
      if (rd_pend)
        rsp_valid <= 1'b1;
      else if (rsp_ready)
        rsp_valid <= 1'b0;
    end
  end

  // response word, held until the handshake
  always_ff @(posedge clka)
  begin
    if (rd_pend)
      rsp_data <= ram_rdata;
  end

endmodule

//--- logic/sp_ram_bytewise.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module sp_ram_bytewise
(
  input  logic               clka,
  input  logic               en,
  // per lane write enable
  input  mem_pkg::mem_be_t   we,
  input  mem_pkg::mem_addr_t addr,
  input  mem_pkg::mem_data_t wdata,
  output mem_pkg::mem_data_t rdata
);

  // full address range
  localparam int DEPTH = 1 << `MEM_ADDR_W;

  mem_pkg::mem_data_t mem [DEPTH];

  // array starts out cleared
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = '0;
  end

  // --------------------------------------------------
  // access port
  // --------------------------------------------------

  // read returns the old word on a write cycle
  always @(posedge clka)
  begin
    if (en)
    begin
      rdata <= mem[addr];
      // merge only the enabled lanes
      for (int b = 0; b < `MEM_BE_W; b++)
      begin
        if (we[b])
          mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
      end
    end
  end

endmodule

//--- mem_cmd_top.f
+incdir+common
common/mem_pkg.sv
common/cmd_credit_if.sv
cmd_buffer/cmd_sdp_ram.sv
cmd_buffer/cmd_buffer.sv
logic/sp_ram_bytewise.sv
logic/mem_consumer.sv
logic/cmd_producer.sv
logic/mem_cmd_top.sv
dv/tb_mem_cmd_top.sv
